// File: img_pkg.sv
package img_pkg;

    // ==============================
    // Widths and sizes
    // ==============================
    localparam int WORD_W          = 16;
    localparam int PIXEL_W         = 12;
    localparam int DIM_W           = 12;
    localparam int STAT_W          = 18;
    localparam int HEADER_WORDS    = 8;
    localparam int STAT_CLASS_BITS = 7;

    typedef logic [WORD_W-1:0]              word_t;
    typedef logic [PIXEL_W-1:0]             pixel_t;
    typedef logic [DIM_W-1:0]               dim_t;
    typedef logic [STAT_W-1:0]              stat_t;
    typedef logic [HEADER_WORDS*WORD_W-1:0] header_t;

    // ==============================
    // Port bundles
    // ==============================
    typedef struct packed {
        logic    capture;   // one-cycle pulse
        header_t header;
    } cmd_t;

    typedef struct packed {
        pixel_t d;
        logic   fv;
        logic   lv;
    } img_in_t;

    typedef struct packed {
        logic  done;        // one-cycle pulse
        logic  overflow;
        dim_t  width;
        dim_t  height;
        stat_t highlight;
        stat_t shadow;
    } capture_status_t;

    // Producer write into the frame buffer
    typedef struct packed {
        logic  en;
        word_t data;
    } buf_wr_t;

endpackage

// File: pixel_capture.sv
`timescale 1ns/1ps

module pixel_capture (
    input  logic                     clk,
    input  logic                     fifoIn_rst,
    input  img_pkg::cmd_t            cmd,
    input  img_pkg::img_in_t         img,
    input  logic                     full,
    output img_pkg::buf_wr_t         buf_wr,
    output logic                     clear,
    output img_pkg::capture_status_t status
);
    import img_pkg::*;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_HEADER,
        ST_WAIT_FV_LOW,
        ST_WAIT_FV_HIGH,
        ST_FRAME
    } state_t;

    localparam int HDR_CNT_W = $clog2(HEADER_WORDS);

    state_t               state;
    header_t              hdr_sr;
    logic [HDR_CNT_W-1:0] hdr_cnt;
    img_in_t              img_q;
    logic                 lv_prev;
    logic [1:0]           col;
    logic [1:0]           row;
    logic                 pix_ok;
    logic                 wr_en;
    word_t                wr_data;
    logic                 stat_en;
    pixel_t               stat_px;
    logic                 done_dly;
    logic                 done_q;
    logic                 overflow;
    dim_t                 width;
    dim_t                 height;
    stat_t                highlight;
    stat_t                shadow;

    // A valid pixel once the frame has opened after the idle gap
    assign pix_ok = img_q.fv && img_q.lv &&
                    (state == ST_FRAME || state == ST_WAIT_FV_HIGH);

    // Buffer is emptied on the same edge the capture is seen
    assign clear = cmd.capture;

    // ==============================
    // Control and statistics
    // ==============================
    always_ff @(posedge clk) begin
        img_q.d <= img.d;
        stat_px <= img_q.d;
        if (!fifoIn_rst) begin
            img_q.fv  <= 1'b0;
            img_q.lv  <= 1'b0;
            lv_prev   <= 1'b0;
            col       <= '0;
            row       <= '0;
            state     <= ST_IDLE;
            hdr_cnt   <= '0;
            wr_en     <= 1'b0;
            stat_en   <= 1'b0;
            done_dly  <= 1'b0;
            done_q    <= 1'b0;
            overflow  <= 1'b0;
            width     <= '0;
            height    <= '0;
            highlight <= '0;
            shadow    <= '0;
        end else begin
            img_q.fv <= img.fv;
            img_q.lv <= img.lv;
            lv_prev  <= img_q.lv;
            wr_en    <= pix_ok;
            done_dly <= 1'b0;
            done_q   <= done_dly;
            stat_en  <= pix_ok && (col == 2'd0) && (row == 2'd0);

            // Position of the registered pixel modulo four
            if (!img_q.lv) begin
                col <= '0;
            end else begin
                col <= col + 2'd1;
            end
            if (!img_q.fv) begin
                row <= '0;
            end else if (lv_prev && !img_q.lv) begin
                row <= row + 2'd1;
            end

            if (pix_ok) begin
                // First pixel of a line restarts the width and opens a new row
                if (!lv_prev) begin
                    width  <= dim_t'(1);
                    height <= height + dim_t'(1);
                end else begin
                    width <= width + dim_t'(1);
                end
            end

            if (stat_en) begin
                if (&stat_px[PIXEL_W-1 -: STAT_CLASS_BITS]) begin
                    highlight <= highlight + stat_t'(1);
                end else if (~|stat_px[PIXEL_W-1 -: STAT_CLASS_BITS]) begin
                    shadow <= shadow + stat_t'(1);
                end
            end

            // Remember a word that the full buffer dropped
            if (wr_en && full) begin
                overflow <= 1'b1;
            end

            case (state)
                ST_IDLE: begin
                end
                ST_HEADER: begin
                    wr_en   <= 1'b1;
                    hdr_cnt <= hdr_cnt + 1'b1;
                    if (hdr_cnt == HDR_CNT_W'(HEADER_WORDS - 1)) begin
                        state <= ST_WAIT_FV_LOW;
                    end
                end
                ST_WAIT_FV_LOW: begin
                    if (!img_q.fv) begin
                        state <= ST_WAIT_FV_HIGH;
                    end
                end
                ST_WAIT_FV_HIGH: begin
                    if (img_q.fv) begin
                        state <= ST_FRAME;
                    end
                end
                ST_FRAME: begin
                    if (!img_q.fv) begin
                        state    <= ST_IDLE;
                        done_dly <= 1'b1;
                    end
                end
                default: state <= ST_IDLE;
            endcase

            // Capture restarts everything that was in progress
            if (cmd.capture) begin
                state     <= ST_HEADER;
                hdr_cnt   <= '0;
                wr_en     <= 1'b0;
                stat_en   <= 1'b0;
                done_dly  <= 1'b0;
                done_q    <= 1'b0;
                overflow  <= 1'b0;
                width     <= '0;
                height    <= '0;
                highlight <= '0;
                shadow    <= '0;
            end
        end
    end

    // ==============================
    // Header shifter and write data
    // ==============================
    always_ff @(posedge clk) begin
        if (cmd.capture) begin
            hdr_sr <= cmd.header;
        end else if (state == ST_HEADER) begin
            hdr_sr <= hdr_sr << WORD_W;
        end
        if (state == ST_HEADER) begin
            wr_data <= hdr_sr[$bits(header_t)-1 -: WORD_W];
        end else begin
            wr_data <= {{(WORD_W - PIXEL_W){1'b0}}, img_q.d};
        end
    end

    assign buf_wr = buf_wr_t'{en: wr_en, data: wr_data};

    assign status = capture_status_t'{
        done:      done_q,
        overflow:  overflow,
        width:     width,
        height:    height,
        highlight: highlight,
        shadow:    shadow
    };

endmodule

// File: frame_buffer.sv
`timescale 1ns/1ps

module frame_buffer #(
    parameter int BUF_DEPTH = 256
) (
    input  logic             clk,
    input  logic             fifoIn_rst,
    input  logic             clear,
    input  img_pkg::buf_wr_t wr,
    input  logic             rd_en,
    output img_pkg::word_t   rd_data,
    output logic             full,
    output logic             empty
);
    import img_pkg::*;

    localparam int PTR_W = (BUF_DEPTH > 1) ? $clog2(BUF_DEPTH) : 1;

    word_t            mem [BUF_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W:0]   count;
    logic             do_wr;
    logic             do_rd;

    // Pointers wrap at the last word so any depth works
    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        next_ptr = (ptr == PTR_W'(BUF_DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign full    = (count == (PTR_W + 1)'(BUF_DEPTH));
    assign empty   = (count == '0);
    assign do_wr   = wr.en && !full && !clear;
    assign do_rd   = rd_en && !empty && !clear;
    assign rd_data = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (!fifoIn_rst || clear) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_wr) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (do_rd) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            case ({do_wr, do_rd})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // Word storage
    always_ff @(posedge clk) begin
        if (do_wr) begin
            mem[wr_ptr] <= wr.data;
        end
    end

endmodule

// File: wb_readout.sv
`timescale 1ns/1ps

module wb_readout (
    input  logic           clk,
    input  logic           fifoIn_rst,

    // Wishbone classic read-only slave
    input  logic           wb_cyc,
    input  logic           wb_stb,
    output logic           wb_ack,
    output img_pkg::word_t wb_dat,

    // Frame buffer read side
    input  img_pkg::word_t rd_data,
    input  logic           empty,
    output logic           rd_en
);
    import img_pkg::*;

    logic  req;
    logic  take;
    word_t dat_q;

    assign req  = wb_cyc && wb_stb;

    // One word per request and never two acks back to back
    assign take = req && !wb_ack && !empty;

    // Pop on the same edge the word is latched
    assign rd_en = take;

    always_ff @(posedge clk) begin
        if (!fifoIn_rst) begin
            wb_ack <= 1'b0;
        end else begin
            wb_ack <= take;
        end
    end

    // Read data holds until the next accepted read
    always_ff @(posedge clk) begin
        if (take) begin
            dat_q <= rd_data;
        end
    end

    assign wb_dat = dat_q;

endmodule

// File: img_capture_top.sv
`timescale 1ns/1ps

module img_capture_top #(
    parameter int BUF_DEPTH = 256
) (
    input  logic                     clk,
    input  logic                     fifoIn_rst,

    // Command, camera and status
    input  img_pkg::cmd_t            cmd,
    input  img_pkg::img_in_t         img,
    output img_pkg::capture_status_t status,

    // Wishbone readout
    input  logic                     wb_cyc,
    input  logic                     wb_stb,
    output logic                     wb_ack,
    output img_pkg::word_t           wb_dat
);
    import img_pkg::*;

    buf_wr_t buf_wr;
    logic    buf_clear;
    logic    buf_full;
    logic    buf_empty;
    word_t   buf_rd_data;
    logic    buf_rd_en;

    // ==============================
    // Producer
    // ==============================
    pixel_capture u_pixel_capture (
        .clk        (clk),
        .fifoIn_rst (fifoIn_rst),
        .cmd        (cmd),
        .img        (img),
        .full       (buf_full),
        .buf_wr     (buf_wr),
        .clear      (buf_clear),
        .status     (status)
    );

    // ==============================
    // Buffer
    // ==============================
    frame_buffer #(
        .BUF_DEPTH (BUF_DEPTH)
    ) u_frame_buffer (
        .clk        (clk),
        .fifoIn_rst (fifoIn_rst),
        .clear      (buf_clear),
        .wr         (buf_wr),
        .rd_en      (buf_rd_en),
        .rd_data    (buf_rd_data),
        .full       (buf_full),
        .empty      (buf_empty)
    );

    // ==============================
    // Consumer
    // ==============================
    wb_readout u_wb_readout (
        .clk        (clk),
        .fifoIn_rst (fifoIn_rst),
        .wb_cyc     (wb_cyc),
        .wb_stb     (wb_stb),
        .wb_ack     (wb_ack),
        .wb_dat     (wb_dat),
        .rd_data    (buf_rd_data),
        .empty      (buf_empty),
        .rd_en      (buf_rd_en)
    );

endmodule

// File: tb_img_capture_tasks.svh
`ifndef TB_IMG_CAPTURE_TASKS_SVH
`define TB_IMG_CAPTURE_TASKS_SVH

// ==============================
// Reporting
// ==============================
task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("*** FAILED ***");
    $fatal(1, "simulation stopped on error");
endtask

task automatic check_value(input string test, input logic [31:0] expected,
                           input logic [31:0] actual);
    if (actual !== expected) begin
        abort_run($sformatf("CHECK FAILED: %s expected 0x%0h actual 0x%0h",
                            test, expected, actual));
    end
endtask

// ==============================
// Camera side
// ==============================
function automatic header_t random_header();
    header_t hdr;
    int      i;
    hdr = '0;
    for (i = 0; i < HEADER_WORDS; i++) begin
        hdr = {hdr[$bits(header_t)-WORD_W-1:0], WORD_W'(random_bits(WORD_W))};
    end
    return hdr;
endfunction

task automatic build_frame(input int w, input int h);
    int     r;
    int     c;
    int     s;
    pixel_t p;
    px.delete();
    s = 0;
    for (r = 0; r < h; r++) begin
        for (c = 0; c < w; c++) begin
            p = pixel_t'(random_bits(PIXEL_W));
            if (r % 4 == 0 && c % 4 == 0) begin
                // Sampled positions cycle through highlight, shadow and mid grey
                case (s % 3)
                    0:       p[PIXEL_W-1 -: STAT_CLASS_BITS] = '1;
                    1:       p[PIXEL_W-1 -: STAT_CLASS_BITS] = '0;
                    default: p[PIXEL_W-1 -: STAT_CLASS_BITS] = 7'h2a;
                endcase
                s++;
            end else if ((r == 0 && c == 1) || (r == 1 && c == 0)) begin
                // Bright pixels just off the sample grid on each axis
                p[PIXEL_W-1 -: STAT_CLASS_BITS] = '1;
            end
            px.push_back(p);
        end
    end
endtask

task automatic start_capture(input header_t hdr);
    @(posedge clk);
    cmd.capture <= 1'b1;
    cmd.header  <= hdr;
    @(posedge clk);
    cmd.capture <= 1'b0;
endtask

// Frame-valid stays low until the header has gone out
task automatic drive_frame(input int w, input int h);
    int r;
    int c;
    repeat (12) @(posedge clk);
    img.fv <= 1'b1;
    repeat (2) @(posedge clk);
    for (r = 0; r < h; r++) begin
        for (c = 0; c < w; c++) begin
            @(posedge clk);
            img.d  <= px[r*w + c];
            img.lv <= 1'b1;
        end
        repeat (3) begin
            @(posedge clk);
            img.lv <= 1'b0;
            img.d  <= '0;
        end
    end
    @(posedge clk);
    img.fv <= 1'b0;
endtask

task automatic wait_done(input string test);
    int n;
    bit seen;
    n    = 0;
    seen = 1'b0;
    while (!seen && n < WAIT_LIMIT) begin
        @(negedge clk);
        seen = status.done;
        n++;
    end
    if (!seen) begin
        abort_run($sformatf("%s: capture never signalled done", test));
    end
endtask

task automatic capture_frame(input string test, input header_t hdr, input int w, input int h);
    build_frame(w, h);
    start_capture(hdr);
    drive_frame(w, h);
    wait_done(test);
endtask

// ==============================
// Wishbone side
// ==============================
task automatic read_word(input string test, output word_t data);
    int n;
    bit got;
    n    = 0;
    got  = 1'b0;
    data = '0;
    @(posedge clk);
    wb_cyc <= 1'b1;
    wb_stb <= 1'b1;
    while (!got && n < WAIT_LIMIT) begin
        @(negedge clk);
        if (wb_ack) begin
            got  = 1'b1;
            data = wb_dat;
        end
        n++;
    end
    @(posedge clk);
    wb_cyc <= 1'b0;
    wb_stb <= 1'b0;
    if (!got) begin
        abort_run($sformatf("%s: read request was never acknowledged", test));
    end
endtask

task automatic expect_no_ack(input string test);
    int n;
    @(posedge clk);
    wb_cyc <= 1'b1;
    wb_stb <= 1'b1;
    for (n = 0; n < STALL_CYCLES; n++) begin
        @(negedge clk);
        check_value(test, 0, wb_ack);
    end
    @(posedge clk);
    wb_cyc <= 1'b0;
    wb_stb <= 1'b0;
endtask

task automatic check_readout(input string test, input header_t hdr, input int n_pix);
    int    i;
    word_t w;
    for (i = 0; i < HEADER_WORDS; i++) begin
        read_word(test, w);
        check_value($sformatf("%s header word %0d", test, i),
                    hdr[(HEADER_WORDS-1-i)*WORD_W +: WORD_W], w);
    end
    for (i = 0; i < n_pix; i++) begin
        read_word(test, w);
        check_value($sformatf("%s pixel %0d", test, i), px[i], w);
    end
endtask

// Model counts over the sample grid of every fourth column and row
task automatic check_status(input string test, input int w, input int h, input logic ovf);
    int     i;
    int     hi;
    int     sh;
    pixel_t p;
    hi = 0;
    sh = 0;
    for (i = 0; i < w*h; i++) begin
        p = px[i];
        if ((i / w) % 4 == 0 && (i % w) % 4 == 0) begin
            if (p[PIXEL_W-1 -: STAT_CLASS_BITS] == '1) begin
                hi++;
            end else if (p[PIXEL_W-1 -: STAT_CLASS_BITS] == '0) begin
                sh++;
            end
        end
    end
    check_value({test, " width"}, w, status.width);
    check_value({test, " height"}, h, status.height);
    check_value({test, " highlight"}, hi, status.highlight);
    check_value({test, " shadow"}, sh, status.shadow);
    check_value({test, " overflow"}, ovf, status.overflow);
endtask

// ==============================
// Directed tests
// ==============================
task automatic check_reset_state();
    @(negedge clk);
    check_value("reset done", 0, status.done);
    check_value("reset overflow", 0, status.overflow);
    check_value("reset wb_ack", 0, wb_ack);
    expect_no_ack("reset read");
endtask

task automatic run_frame_readout();
    header_t hdr;
    hdr = random_header();
    capture_frame("frame 6x4", hdr, 6, 4);
    check_readout("frame 6x4", hdr, 24);
endtask

task automatic check_frame_stats();
    check_status("stats 6x4", 6, 4, 1'b0);
endtask

task automatic check_empty_stall();
    expect_no_ack("empty stall");
endtask

task automatic run_overflow();
    header_t hdr;
    hdr = random_header();
    capture_frame("overflow 10x8", hdr, 10, 8);
    check_status("overflow 10x8", 10, 8, 1'b1);
    check_readout("overflow 10x8", hdr, TB_DEPTH - HEADER_WORDS);
    expect_no_ack("overflow drained");
endtask

task automatic run_recapture();
    header_t hdr;
    hdr = random_header();
    capture_frame("recapture 9x6", hdr, 9, 6);
    check_status("recapture 9x6", 9, 6, 1'b0);
    check_readout("recapture 9x6", hdr, 54);
    expect_no_ack("recapture drained");
endtask

`endif

// File: tb_img_capture.sv
`timescale 1ns/1ps

module tb_img_capture;
    import img_pkg::*;

    localparam int TB_DEPTH     = 64;
    localparam int WAIT_LIMIT   = 200;
    localparam int STALL_CYCLES = 20;

    logic            clk;
    logic            fifoIn_rst;
    cmd_t            cmd;
    img_in_t         img;
    capture_status_t status;
    logic            wb_cyc;
    logic            wb_stb;
    logic            wb_ack;
    word_t           wb_dat;

    // Random source and the pixels of the frame being captured
    logic [31:0] lfsr;
    pixel_t      px [$];

    img_capture_top #(
        .BUF_DEPTH (TB_DEPTH)
    ) u_img_capture_top (
        .clk        (clk),
        .fifoIn_rst (fifoIn_rst),
        .cmd        (cmd),
        .img        (img),
        .status     (status),
        .wb_cyc     (wb_cyc),
        .wb_stb     (wb_stb),
        .wb_ack     (wb_ack),
        .wb_dat     (wb_dat)
    );

    `include "tb_img_capture_tasks.svh"

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // Galois LFSR stepped once per random bit
    function automatic logic next_bit();
        logic out;
        out  = lfsr[0];
        lfsr = lfsr >> 1;
        if (out) begin
            lfsr = lfsr ^ 32'h80200003;
        end
        return out;
    endfunction

    function automatic logic [31:0] random_bits(input int n);
        logic [31:0] v;
        int          i;
        v = '0;
        for (i = 0; i < n; i++) begin
            v = {v[30:0], next_bit()};
        end
        return v;
    endfunction

    // ==============================
    // Test sequence
    // ==============================
    initial begin
        lfsr       = 32'h0e39d18b;
        fifoIn_rst = 1'b0;
        cmd        = '0;
        img        = '0;
        wb_cyc     = 1'b0;
        wb_stb     = 1'b0;
        repeat (3) @(posedge clk);
        fifoIn_rst <= 1'b1;

        check_reset_state();
        run_frame_readout();
        check_frame_stats();
        check_empty_stall();
        run_overflow();
        run_recapture();

        $display("*** PASSED ***");
        $finish;
    end

endmodule

// File: build.f
+incdir+.
img_pkg.sv
pixel_capture.sv
frame_buffer.sv
wb_readout.sv
img_capture_top.sv
tb_img_capture.sv
